//--- hw/periph_pkg.sv
// Peripheral subsystem constants
package periph_pkg;

    // ------------------------------------------------------------------------
    // APB bus and region map
    // ------------------------------------------------------------------------
    localparam int ApbAddrWidth = 32;
    localparam int ApbDataWidth = 32;

    // Region select bits of paddr
    localparam int RegionMsb = 15;
    localparam int RegionLsb = 12;

    localparam logic [RegionMsb-RegionLsb:0] RegionPlic  = 4'd0;
    localparam logic [RegionMsb-RegionLsb:0] RegionTimer = 4'd1;

    // Answer of the default slave
    localparam logic [ApbDataWidth-1:0] ErrorRdata = 32'hDEAD_BEEF;

    // ------------------------------------------------------------------------
    // Interrupt sources and targets
    // ------------------------------------------------------------------------
    localparam int NumTimers      = 2;
    localparam int NumExtIrq      = 5;
    // Source 0 is reserved, timers follow
    localparam int FirstExtSource = NumTimers + 1;
    localparam int NumSources     = FirstExtSource + NumExtIrq;
    localparam int NumTargets     = 2;

    localparam int MaxPriority = 7;
    localparam int PrioWidth   = $clog2(MaxPriority + 1);
    localparam int SrcIdWidth  = $clog2(NumSources);

    // ------------------------------------------------------------------------
    // Interrupt controller register offsets
    // ------------------------------------------------------------------------
    // Priority of source n at base + 4n
    localparam logic [RegionLsb-1:0] PlicPrioBase   = 12'h000;
    localparam logic [RegionLsb-1:0] PlicPendingOff = 12'h080;
    // Enable of target t at base + 4t
    localparam logic [RegionLsb-1:0] PlicEnableBase = 12'h100;
    // Threshold and claim of target t at base + 8t
    localparam logic [RegionLsb-1:0] PlicThreshBase = 12'h200;
    localparam logic [RegionLsb-1:0] PlicClaimBase  = 12'h204;

    // ------------------------------------------------------------------------
    // Timer register offsets
    // ------------------------------------------------------------------------
    localparam logic [RegionLsb-1:0] TimerStride = 12'h010;

    // Bit 0 enables counting
    localparam logic [RegionLsb-1:0] TimerCtrlOff   = 12'h000;
    localparam logic [RegionLsb-1:0] TimerCountOff  = 12'h004;
    localparam logic [RegionLsb-1:0] TimerCmpOff    = 12'h008;
    // Write 1 to bit 0 clears
    localparam logic [RegionLsb-1:0] TimerStatusOff = 12'h00C;

endpackage

//--- hw/apb_if.sv
// APB bus interface
`timescale 1ns/1ps

interface apb_if;
    import periph_pkg::*;

    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [ApbAddrWidth-1:0] paddr;
    logic [ApbDataWidth-1:0] pwdata;
    logic [ApbDataWidth-1:0] prdata;
    logic                    pready;
    logic                    pslverr;

    // Region decoder side
    modport decoder (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    // Peripheral side
    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

//--- hw/apb_region_decoder.sv
// APB region decoder
`timescale 1ns/1ps

module apb_region_decoder (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [periph_pkg::ApbAddrWidth-1:0] paddr_i,
    input  logic [periph_pkg::ApbDataWidth-1:0] pwdata_i,
    output logic [periph_pkg::ApbDataWidth-1:0] prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    apb_if.decoder                              plic_o,
    apb_if.decoder                              timer_o
);
    import periph_pkg::*;

    logic [RegionMsb-RegionLsb:0] region;
    logic                         access;

    assign region = paddr_i[RegionMsb:RegionLsb];
    assign access = psel_i && penable_i;

    // ------------------------------------------------------------------------
    // Request fan-out
    // ------------------------------------------------------------------------
    assign plic_o.psel    = psel_i && (region == RegionPlic);
    assign plic_o.penable = penable_i;
    assign plic_o.pwrite  = pwrite_i;
    assign plic_o.paddr   = paddr_i;
    assign plic_o.pwdata  = pwdata_i;

    assign timer_o.psel    = psel_i && (region == RegionTimer);
    assign timer_o.penable = penable_i;
    assign timer_o.pwrite  = pwrite_i;
    assign timer_o.paddr   = paddr_i;
    assign timer_o.pwdata  = pwdata_i;

    // ------------------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------------------
    always_comb begin
        case (region)
            RegionPlic: begin
                prdata_o  = plic_o.prdata;
                pready_o  = plic_o.pready;
                pslverr_o = plic_o.pslverr;
            end
            RegionTimer: begin
                prdata_o  = timer_o.prdata;
                pready_o  = timer_o.pready;
                pslverr_o = timer_o.pslverr;
            end
            default: begin
                // Unmapped region, answer with an error
                prdata_o  = ErrorRdata;
                pready_o  = access;
                pslverr_o = access;
            end
        endcase
    end

    // Never more than one peripheral selected
    assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({plic_o.psel, timer_o.psel}));

endmodule

//--- hw/plic_core.sv
// Platform-level interrupt controller
`timescale 1ns/1ps

module plic_core (
    input  logic                              clk_i,
    input  logic                              rst_i,
    apb_if.slave                              bus_i,
    input  logic [periph_pkg::NumSources-1:0] irq_sources_i,
    output logic [periph_pkg::NumTargets-1:0] irq_o
);
    import periph_pkg::*;

    logic [RegionLsb-1:0]  off;
    logic                  access;
    logic                  wr_en;
    logic                  rd_en;

    logic [PrioWidth-1:0]  prio [NumSources];
    logic [NumSources-1:0] enable [NumTargets];
    logic [PrioWidth-1:0]  thresh [NumTargets];
    logic [NumSources-1:0] pending;
    logic [NumSources-1:0] in_flight;

    logic [SrcIdWidth-1:0] claim_id [NumTargets];
    logic [NumTargets-1:0] claim_rd;
    logic [NumTargets-1:0] complete_wr;
    logic [NumSources-1:0] claim_set;
    logic [NumSources-1:0] complete_set;
    logic [NumTargets-1:0] irq_q;

    assign off    = bus_i.paddr[RegionLsb-1:0];
    assign access = bus_i.psel && bus_i.penable;
    assign wr_en  = access && bus_i.pwrite;
    assign rd_en  = access && !bus_i.pwrite;

    // No wait states, no errors
    assign bus_i.pready  = access;
    assign bus_i.pslverr = 1'b0;

    // ------------------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio   <= '{default: '0};
            enable <= '{default: '0};
            thresh <= '{default: '0};
        end else if (wr_en) begin
            // Source 0 keeps priority 0
            for (int n = 1; n < NumSources; n++) begin
                if (off == PlicPrioBase + RegionLsb'(4 * n)) begin
                    prio[n] <= bus_i.pwdata[PrioWidth-1:0];
                end
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (off == PlicEnableBase + RegionLsb'(4 * t)) begin
                    enable[t] <= {bus_i.pwdata[NumSources-1:1], 1'b0};
                end
                if (off == PlicThreshBase + RegionLsb'(8 * t)) begin
                    thresh[t] <= bus_i.pwdata[PrioWidth-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Arbitration per target
    // ------------------------------------------------------------------------
    always_comb begin
        logic [PrioWidth-1:0] best;
        for (int t = 0; t < NumTargets; t++) begin
            best        = thresh[t];
            claim_id[t] = '0;
            // Strictly greater, so lowest ID wins a tie
            for (int n = 1; n < NumSources; n++) begin
                if (pending[n] && enable[t][n] && prio[n] > best) begin
                    best        = prio[n];
                    claim_id[t] = SrcIdWidth'(n);
                end
            end
        end
    end

    for (genvar t = 0; t < NumTargets; t++) begin : g_target
        logic [RegionLsb-1:0] claim_addr;

        assign claim_addr     = PlicClaimBase + RegionLsb'(8 * t);
        assign claim_rd[t]    = rd_en && (off == claim_addr);
        assign complete_wr[t] = wr_en && (off == claim_addr);

        // A claim never hands out a source masked for this target
        assert property (@(posedge clk_i) disable iff (rst_i)
            claim_rd[t] && claim_id[t] != '0 |-> enable[t][claim_id[t]]);
    end

    always_comb begin
        logic [SrcIdWidth-1:0] done_id;
        claim_set    = '0;
        complete_set = '0;
        done_id      = bus_i.pwdata[SrcIdWidth-1:0];
        for (int t = 0; t < NumTargets; t++) begin
            if (claim_rd[t] && claim_id[t] != '0) begin
                claim_set[claim_id[t]] = 1'b1;
            end
            // Completion ignored for sources the target has masked
            if (complete_wr[t] && enable[t][done_id]) begin
                complete_set[done_id] = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Level gateways
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending   <= '0;
            in_flight <= '0;
        end else begin
            for (int n = 0; n < NumSources; n++) begin
                if (claim_set[n]) begin
                    pending[n]   <= 1'b0;
                    in_flight[n] <= 1'b1;
                end else begin
                    if (irq_sources_i[n] && !in_flight[n]) begin
                        pending[n] <= 1'b1;
                    end
                    if (complete_set[n]) begin
                        in_flight[n] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            irq_q <= '0;
        end else begin
            for (int t = 0; t < NumTargets; t++) begin
                irq_q[t] <= (claim_id[t] != '0);
            end
        end
    end

    assign irq_o = irq_q;

    // Read mux
    always_comb begin
        bus_i.prdata = '0;
        for (int n = 0; n < NumSources; n++) begin
            if (off == PlicPrioBase + RegionLsb'(4 * n)) begin
                bus_i.prdata = ApbDataWidth'(prio[n]);
            end
        end
        if (off == PlicPendingOff) begin
            bus_i.prdata = ApbDataWidth'(pending);
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (off == PlicEnableBase + RegionLsb'(4 * t)) begin
                bus_i.prdata = ApbDataWidth'(enable[t]);
            end
            if (off == PlicThreshBase + RegionLsb'(8 * t)) begin
                bus_i.prdata = ApbDataWidth'(thresh[t]);
            end
            if (claim_rd[t]) begin
                bus_i.prdata = ApbDataWidth'(claim_id[t]);
            end
        end
    end

endmodule

//--- hw/apb_timer.sv
// Dual compare timer
`timescale 1ns/1ps

module apb_timer (
    input  logic                             clk_i,
    input  logic                             rst_i,
    apb_if.slave                             bus_i,
    output logic [periph_pkg::NumTimers-1:0] irq_o
);
    import periph_pkg::*;

    logic [RegionLsb-1:0]    off;
    logic                    access;
    logic                    wr_en;
    logic [NumTimers-1:0]    status;
    logic [ApbDataWidth-1:0] tmr_rdata [NumTimers];

    assign off    = bus_i.paddr[RegionLsb-1:0];
    assign access = bus_i.psel && bus_i.penable;
    assign wr_en  = access && bus_i.pwrite;

    assign bus_i.pready  = access;
    assign bus_i.pslverr = 1'b0;

    // ------------------------------------------------------------------------
    // Timer channels
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < NumTimers; i++) begin : g_timer
        logic [RegionLsb-1:0]    base;
        logic                    hit_ctrl;
        logic                    hit_count;
        logic                    hit_cmp;
        logic                    hit_status;
        logic                    en_q;
        logic                    status_q;
        logic [ApbDataWidth-1:0] count_q;
        logic [ApbDataWidth-1:0] cmp_q;
        logic                    match;
        logic [ApbDataWidth-1:0] rd_word;

        assign base       = RegionLsb'(TimerStride * i);
        assign hit_ctrl   = (off == base + TimerCtrlOff);
        assign hit_count  = (off == base + TimerCountOff);
        assign hit_cmp    = (off == base + TimerCmpOff);
        assign hit_status = (off == base + TimerStatusOff);
        assign match      = en_q && (count_q == cmp_q);

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                en_q     <= 1'b0;
                status_q <= 1'b0;
                count_q  <= '0;
                cmp_q    <= '0;
            end else begin
                if (wr_en && hit_ctrl) begin
                    en_q <= bus_i.pwdata[0];
                end
                if (wr_en && hit_cmp) begin
                    cmp_q <= bus_i.pwdata;
                end
                // Bus write beats the counter
                if (wr_en && hit_count) begin
                    count_q <= bus_i.pwdata;
                end else if (match) begin
                    count_q <= '0;
                end else if (en_q) begin
                    count_q <= count_q + 1'b1;
                end
                // New event wins over a clear in the same cycle
                if (match) begin
                    status_q <= 1'b1;
                end else if (wr_en && hit_status && bus_i.pwdata[0]) begin
                    status_q <= 1'b0;
                end
            end
        end

        always_comb begin
            rd_word = '0;
            if (hit_ctrl)   rd_word = ApbDataWidth'(en_q);
            if (hit_count)  rd_word = count_q;
            if (hit_cmp)    rd_word = cmp_q;
            if (hit_status) rd_word = ApbDataWidth'(status_q);
        end

        assign tmr_rdata[i] = rd_word;
        assign status[i]    = status_q;
    end

    always_comb begin
        bus_i.prdata = '0;
        for (int i = 0; i < NumTimers; i++) begin
            bus_i.prdata = bus_i.prdata | tmr_rdata[i];
        end
    end

    assign irq_o = status;

    // Every setup is answered in the very next cycle
    assert property (@(posedge clk_i) disable iff (rst_i)
        bus_i.psel && !bus_i.penable |=> bus_i.penable && bus_i.pready);

endmodule

//--- hw/periph_subsys.sv
// Peripheral subsystem top
`timescale 1ns/1ps

module periph_subsys (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [periph_pkg::ApbAddrWidth-1:0] paddr_i,
    input  logic [periph_pkg::ApbDataWidth-1:0] pwdata_i,
    output logic [periph_pkg::ApbDataWidth-1:0] prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    input  logic [periph_pkg::NumExtIrq-1:0]    ext_irq_i,
    output logic [periph_pkg::NumTargets-1:0]   irq_o
);
    import periph_pkg::*;

    logic [NumTimers-1:0]  timer_irq;
    logic [NumSources-1:0] irq_sources;

    apb_if plic_bus ();
    apb_if timer_bus ();

    // Source 0 means none, then timers, then external lines
    assign irq_sources[0]                           = 1'b0;
    assign irq_sources[FirstExtSource-1:1]          = timer_irq;
    assign irq_sources[NumSources-1:FirstExtSource] = ext_irq_i;

    apb_region_decoder i_decoder (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .plic_o    ( plic_bus  ),
        .timer_o   ( timer_bus )
    );

    plic_core i_plic (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .bus_i         ( plic_bus    ),
        .irq_sources_i ( irq_sources ),
        .irq_o         ( irq_o       )
    );

    apb_timer i_timer (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .bus_i ( timer_bus ),
        .irq_o ( timer_irq )
    );

endmodule

//--- bench/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // Reset held for two cycles, released away from the rising edge
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- bench/periph_subsys_tb.sv
// Peripheral subsystem testbench
`timescale 1ns/1ps

module periph_subsys_tb;
    import periph_pkg::*;

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [ApbAddrWidth-1:0] paddr;
    logic [ApbDataWidth-1:0] pwdata;
    logic [ApbDataWidth-1:0] prdata;
    logic                    pready;
    logic                    pslverr;
    logic [NumExtIrq-1:0]    ext_irq;
    logic [NumTargets-1:0]   irq;

    // Expected values armed by the stimulus
    logic [ApbDataWidth-1:0] rd_exp;
    logic [ApbDataWidth-1:0] rd_mask;
    logic [ApbDataWidth-1:0] rd_q;
    logic                    expect_err;
    logic [NumTargets-1:0]   irq_exp;
    logic [NumTargets-1:0]   irq_mask;
    int                      mismatches;
    int                      timeouts;
    int                      seed;

    localparam logic [ApbDataWidth-1:0] PrioMask = ApbDataWidth'((1 << PrioWidth) - 1);
    localparam logic [ApbDataWidth-1:0] SrcMask  = ApbDataWidth'((1 << NumSources) - 2);
    localparam logic [ApbDataWidth-1:0] AllBits  = '1;

    tb_clk_gen i_clk_gen (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    periph_subsys DUT (
        .clk_i     ( clk     ),
        .rst_i     ( rst     ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .ext_irq_i ( ext_irq ),
        .irq_o     ( irq     )
    );

    always_ff @(posedge clk) begin
        if (psel && penable) begin
            rd_q <= prdata;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (rst)
        psel && penable && !pwrite && rd_mask != '0 |-> (prdata & rd_mask) == (rd_exp & rd_mask))
        else begin
            mismatches++;
            $display("Mismatch at %0t: read 0x%08h at 0x%08h, expected 0x%08h",
                     $time, $sampled(prdata), $sampled(paddr), $sampled(rd_exp));
        end

    assert property (@(posedge clk) disable iff (rst)
        psel && penable |-> pready && pslverr == expect_err)
        else begin
            mismatches++;
            $display("Mismatch at %0t: pready %0b pslverr %0b at 0x%08h",
                     $time, $sampled(pready), $sampled(pslverr), $sampled(paddr));
        end

    assert property (@(posedge clk) disable iff (rst)
        irq_mask != '0 |-> (irq & irq_mask) == (irq_exp & irq_mask))
        else begin
            mismatches++;
            $display("Mismatch at %0t: irq_o is %b, expected %b under mask %b",
                     $time, $sampled(irq), $sampled(irq_exp), $sampled(irq_mask));
        end

    // ------------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------------
    function automatic logic [ApbAddrWidth-1:0] reg_addr(input logic [3:0] region,
                                                        input logic [11:0] off);
        return {16'h0000, region, off};
    endfunction

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp,
                            input logic [31:0] mask, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        rd_exp  = exp;
        rd_mask = mask;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        rd_mask = '0;
        data    = rd_q;
    endtask

    task automatic wait_irq(input int target, input logic level, input int max_cycles);
        int n;
        n = 0;
        while (irq[target] !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (irq[target] !== level) begin
            timeouts++;
            $display("Timeout at %0t: irq_o[%0d] never went to %0b", $time, target, level);
        end
    endtask

    task automatic wait_timer_status(input int idx, input int max_polls);
        logic [31:0] data;
        int          n;
        n    = 0;
        data = '0;
        while (data[0] !== 1'b1 && n < max_polls) begin
            apb_read(reg_addr(RegionTimer, 12'(TimerStride * idx) + TimerStatusOff),
                     '0, '0, data);
            n++;
        end
        if (data[0] !== 1'b1) begin
            timeouts++;
            $display("Timeout at %0t: status of timer %0d was never set", $time, idx);
        end
    endtask

    task automatic wait_reset_release(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (rst !== 1'b0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("Timeout at %0t: reset was never released", $time);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------------------
    task automatic clear_config();
        for (int n = 1; n < NumSources; n++) begin
            apb_write(reg_addr(RegionPlic, PlicPrioBase + 12'(4 * n)), '0);
        end
        for (int t = 0; t < NumTargets; t++) begin
            apb_write(reg_addr(RegionPlic, PlicEnableBase + 12'(4 * t)), '0);
            apb_write(reg_addr(RegionPlic, PlicThreshBase + 12'(8 * t)), '0);
        end
        for (int i = 0; i < NumTimers; i++) begin
            apb_write(reg_addr(RegionTimer, 12'(TimerStride * i) + TimerCtrlOff), '0);
            apb_write(reg_addr(RegionTimer, 12'(TimerStride * i) + TimerCountOff), '0);
            apb_write(reg_addr(RegionTimer, 12'(TimerStride * i) + TimerCmpOff), '0);
            apb_write(reg_addr(RegionTimer, 12'(TimerStride * i) + TimerStatusOff), 32'h1);
        end
    endtask

    task automatic check_error_slave();
        logic [31:0] data;
        expect_err = 1'b1;
        apb_read(32'h0000_5000, ErrorRdata, AllBits, data);
        apb_write(32'h0000_5004, $random(seed));
        expect_err = 1'b0;
        apb_read(reg_addr(RegionPlic, PlicPendingOff), '0, '0, data);
        apb_read(reg_addr(RegionTimer, TimerCountOff), '0, '0, data);
    endtask

    task automatic check_readback();
        logic [31:0] wdata;
        logic [31:0] data;
        logic [31:0] addr;
        for (int n = 0; n < NumSources; n++) begin
            wdata = $random(seed);
            addr  = reg_addr(RegionPlic, PlicPrioBase + 12'(4 * n));
            apb_write(addr, wdata);
            apb_read(addr, (n == 0) ? '0 : (wdata & PrioMask), AllBits, data);
        end
        for (int t = 0; t < NumTargets; t++) begin
            wdata = $random(seed);
            addr  = reg_addr(RegionPlic, PlicEnableBase + 12'(4 * t));
            apb_write(addr, wdata);
            apb_read(addr, wdata & SrcMask, AllBits, data);
            wdata = $random(seed);
            addr  = reg_addr(RegionPlic, PlicThreshBase + 12'(8 * t));
            apb_write(addr, wdata);
            apb_read(addr, wdata & PrioMask, AllBits, data);
        end
        for (int i = 0; i < NumTimers; i++) begin
            wdata = $random(seed);
            addr  = reg_addr(RegionTimer, 12'(TimerStride * i) + TimerCmpOff);
            apb_write(addr, wdata);
            apb_read(addr, wdata, AllBits, data);
            wdata = $random(seed);
            addr  = reg_addr(RegionTimer, 12'(TimerStride * i) + TimerCtrlOff);
            apb_write(addr, wdata);
            apb_read(addr, wdata & 32'h1, AllBits, data);
        end
        clear_config();
    endtask

    task automatic check_timer_irq();
        logic [31:0] data;
        logic [31:0] claim0;
        claim0 = reg_addr(RegionPlic, PlicClaimBase);
        apb_write(reg_addr(RegionTimer, TimerStride + TimerCmpOff), 32'd20);
        apb_write(reg_addr(RegionPlic, PlicPrioBase + 12'(4 * 2)), 32'd4);
        apb_write(reg_addr(RegionPlic, PlicEnableBase), 32'h1 << 2);
        apb_write(reg_addr(RegionPlic, PlicThreshBase), '0);
        apb_write(reg_addr(RegionTimer, TimerStride + TimerCtrlOff), 32'h1);
        wait_timer_status(1, 20);
        wait_irq(0, 1'b1, 10);
        apb_read(claim0, 32'd2, AllBits, data);
        apb_write(reg_addr(RegionTimer, TimerStride + TimerCtrlOff), '0);
        apb_write(reg_addr(RegionTimer, TimerStride + TimerStatusOff), 32'h1);
        apb_write(claim0, 32'd2);
        wait_irq(0, 1'b0, 10);
        // Quiet line keeps the gateway closed
        irq_exp  = '0;
        irq_mask = 2'b01;
        apb_read(reg_addr(RegionPlic, PlicPendingOff), '0, 32'h4, data);
        irq_mask = '0;
        clear_config();
    endtask

    task automatic check_arbitration();
        logic [31:0] data;
        logic [31:0] claim0;
        claim0 = reg_addr(RegionPlic, PlicClaimBase);
        apb_write(reg_addr(RegionPlic, PlicPrioBase + 12'(4 * 3)), 32'd2);
        apb_write(reg_addr(RegionPlic, PlicPrioBase + 12'(4 * 5)), 32'd6);
        apb_write(reg_addr(RegionPlic, PlicEnableBase), (32'h1 << 3) | (32'h1 << 5));
        @(negedge clk);
        ext_irq = 5'b00101;
        wait_irq(0, 1'b1, 10);
        apb_read(claim0, 32'd5, AllBits, data);
        apb_write(claim0, 32'd5);
        // Lowest ID wins between equal priorities
        apb_write(reg_addr(RegionPlic, PlicPrioBase + 12'(4 * 5)), 32'd2);
        apb_read(claim0, 32'd3, AllBits, data);
        apb_write(claim0, 32'd3);
        apb_write(reg_addr(RegionPlic, PlicPrioBase + 12'(4 * 5)), 32'd6);
        apb_write(reg_addr(RegionPlic, PlicThreshBase), 32'd6);
        apb_read(claim0, '0, AllBits, data);
        irq_exp  = '0;
        irq_mask = 2'b01;
        apb_read(reg_addr(RegionPlic, PlicPendingOff), '0, '0, data);
        apb_read(claim0, '0, AllBits, data);
        irq_mask = '0;
        ext_irq  = '0;
        apb_write(reg_addr(RegionPlic, PlicEnableBase), '0);
        apb_write(reg_addr(RegionPlic, PlicThreshBase), '0);
    endtask

    task automatic check_claim_targets();
        logic [31:0] data;
        logic [31:0] claim1;
        claim1 = reg_addr(RegionPlic, PlicClaimBase + 12'(8));
        apb_write(reg_addr(RegionPlic, PlicPrioBase + 12'(4 * 7)), 32'd1);
        apb_write(reg_addr(RegionPlic, PlicEnableBase + 12'(4)), 32'h1 << 7);
        apb_write(reg_addr(RegionPlic, PlicThreshBase + 12'(8)), '0);
        // Target 0 has nothing enabled
        irq_exp  = '0;
        irq_mask = 2'b01;
        @(negedge clk);
        ext_irq[4] = 1'b1;
        wait_irq(1, 1'b1, 10);
        // Only target 1 sees the line
        irq_exp  = 2'b10;
        irq_mask = 2'b11;
        apb_read(claim1, 32'd7, AllBits, data);
        irq_exp  = '0;
        irq_mask = 2'b01;
        wait_irq(1, 1'b0, 10);
        apb_write(claim1, 32'd7);
        wait_irq(1, 1'b1, 10);
        ext_irq[4] = 1'b0;
        apb_read(claim1, 32'd7, AllBits, data);
        apb_write(claim1, 32'd7);
        wait_irq(1, 1'b0, 10);
        irq_mask = '0;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        ext_irq    = '0;
        rd_exp     = '0;
        rd_mask    = '0;
        expect_err = 1'b0;
        irq_exp    = '0;
        irq_mask   = '0;
        mismatches = 0;
        timeouts   = 0;
        seed       = 32'h844c_095b;

        wait_reset_release(10);

        check_error_slave();
        check_readback();
        check_timer_irq();
        check_arbitration();
        check_claim_targets();

        repeat (2) @(negedge clk);
        $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
hw/periph_pkg.sv
hw/apb_if.sv
hw/apb_region_decoder.sv
hw/plic_core.sv
hw/apb_timer.sv
hw/periph_subsys.sv
bench/tb_clk_gen.sv
bench/periph_subsys_tb.sv

//--- Makefile
# Verilator flow for the peripheral subsystem

TOP := periph_subsys_tb

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -qF '*** FAILED ***' sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
